/* sources.f */
+incdir+tests
common/fmc_apb_pkg.sv
fmc_bridge/fmc_apb_bridge.sv
logic/apb_decoder.sv
logic/apb_reg_bank.sv
logic/apb_sram.sv
logic/fmc_apb_top.sv
tests/fmc_apb_tb.sv

/* Makefile */
BIN  := obj_dir/Vfmc_apb_tb
SRCS := $(filter-out +%,$(shell cat sources.f)) tests/fmc_host_tasks.svh

.PHONY: all run clean

all: $(BIN)

$(BIN): sources.f $(SRCS)
	verilator --binary -Wno-fatal --top-module fmc_apb_tb -f sources.f

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'all tests passed'

clean:
	rm -rf obj_dir

/* tests/fmc_host_tasks.svh */
////////////////////////////////////////
// FMC host timing

// Inputs change here
task automatic next_fall();
	@(negedge apb);
endtask

// Midway to the rising edge, outputs are stable for that edge
task automatic settle();
	#(half_period / 2);
endtask

// Address phase, entered at a falling edge
// Two cycles of address with nadv low
task automatic drive_address(input logic [18:0] addr, input logic wr);
	fmc_cs_n    = 1'b0;
	fmc_nl_nadv = 1'b0;
	fmc_nwe     = ~wr;
	fmc_noe     = 1'b1;
	fmc_nbl     = 2'b00;
	fmc_a_hi    = addr[18:16];
	// AD carries byte address bits 16..1
	ad_val      = addr[16:1];
	ad_drive    = 1'b1;
	next_fall();
	next_fall();
	fmc_nl_nadv = 1'b1;
endtask

// Keep the current drive until a rising edge sees nwait high
task automatic hold_until_ready();
	settle();
	while (fmc_nwait !== 1'b1) begin
		next_fall();
		settle();
	end
endtask

// Deselect for two cycles, nwait must stay high meanwhile
task automatic release_bus();
	next_fall();
	fmc_cs_n = 1'b1;
	fmc_nwe  = 1'b1;
	fmc_noe  = 1'b1;
	fmc_nbl  = 2'b11;
	ad_drive = 1'b0;
	repeat (2) begin
		settle();
		if (fmc_nwait !== 1'b1) begin
			errors = errors + 1;
			$display("fmc_nwait was low while fmc_cs_n was high after %s", name_q[cur_idx]);
		end
		next_fall();
	end
endtask

////////////////////////////////////////
// Transactions

// Low half first, each half with its own lanes
task automatic write_word(input logic [18:0] addr, input logic [31:0] data,
	input logic [3:0] lanes);
	drive_address(addr, 1'b1);
	ad_val  = data[15:0];
	fmc_nbl = ~lanes[1:0];
	hold_until_ready();
	next_fall();
	ad_val  = data[31:16];
	fmc_nbl = ~lanes[3:2];
	hold_until_ready();
	release_bus();
endtask

// Bus turnaround, then the two halves after nwait rises
task automatic read_word(input logic [18:0] addr, output logic [31:0] data);
	drive_address(addr, 1'b0);
	ad_drive = 1'b0;
	fmc_noe  = 1'b0;
	hold_until_ready();
	next_fall();
	settle();
	data[15:0] = fmc_ad;
	next_fall();
	settle();
	data[31:16] = fmc_ad;
	release_bus();
endtask

/* tests/fmc_apb_tb.sv */
`timescale 1ns/10ps

module fmc_apb_tb;

	localparam int          sram_words  = 256;
	localparam bit          early_read  = 1'b1;
	localparam int          half_period = 20;
	// Read-only ID, "FMCA"
	localparam logic [31:0] id_word     = 32'h464d_4341;

	// One row of the stimulus table
	typedef struct packed {
		logic        wr;
		logic        computed;
		logic [18:0] addr;
		logic [31:0] data;
		logic [3:0]  lanes;
		logic [31:0] expv;
	} vec_t;

	logic        apb;
	logic        rst_n;
	logic        fmc_cs_n;
	logic        fmc_nl_nadv;
	logic        fmc_nwe;
	logic        fmc_noe;
	logic [1:0]  fmc_nbl;
	logic [2:0]  fmc_a_hi;
	wire  [15:0] fmc_ad;
	logic        fmc_nwait;

	// Host driver on the shared AD bus
	logic        ad_drive;
	logic [15:0] ad_val;

	vec_t        table_q[$];
	string       name_q[$];

	// Shadow of the completers
	logic [31:0] sram_shadow [sram_words];
	logic [31:0] scratch_shadow;
	logic [31:0] count_shadow;

	int          errors = 0;
	int          checks = 0;
	int          cycles = 0;
	int          cur_idx = -1;

	assign fmc_ad = ad_drive ? ad_val : 16'hzzzz;

	fmc_apb_top #(
		.early_read (early_read),
		.sram_words (sram_words)
	) fmc_apb_top_i (
		.apb         (apb),
		.rst_n       (rst_n),
		.fmc_cs_n    (fmc_cs_n),
		.fmc_nl_nadv (fmc_nl_nadv),
		.fmc_nwe     (fmc_nwe),
		.fmc_noe     (fmc_noe),
		.fmc_nbl     (fmc_nbl),
		.fmc_a_hi    (fmc_a_hi),
		.fmc_ad      (fmc_ad),
		.fmc_nwait   (fmc_nwait)
	);

	`include "fmc_host_tasks.svh"

	always #(half_period) apb = ~apb;

	////////////////////////////////////////
	// Watchdog

	// Budget of 60 cycles per entry plus 20
	always @(posedge apb) begin
		cycles = cycles + 1;
		if (cycles >= 60 * table_q.size() + 20) begin
			if (cur_idx < 0) begin
				$display("timeout before the first table entry started");
			end else begin
				$display("timeout: entry %0d (%s) never completed", cur_idx, name_q[cur_idx]);
			end
			$display("summary: %0d checks, %0d errors", checks, errors);
			$display("tests failed");
			$finish;
		end
	end

	////////////////////////////////////////
	// Shadow model

	// Region by bit 18, register window by bits 17..6
	function automatic logic [31:0] predict_read(input logic [18:0] addr);
		logic [31:0] val;
		val = '0;
		if (addr[18]) begin
			val = sram_shadow[int'(addr[17:2]) % sram_words];
		end else if (addr[17:6] == 12'd0) begin
			case (addr[5:2])
				4'd0:    val = id_word;
				4'd1:    val = scratch_shadow;
				4'd2:    val = count_shadow;
				default: val = '0;
			endcase
		end
		return val;
	endfunction

	function automatic void apply_write(input logic [18:0] addr, input logic [31:0] data,
		input logic [3:0] lanes);
		int idx;
		idx = int'(addr[17:2]) % sram_words;
		if (addr[18]) begin
			for (int b = 0; b < 4; b++) begin
				if (lanes[b]) begin
					sram_shadow[idx][8*b +: 8] = data[8*b +: 8];
				end
			end
		end else begin
			// Any completed write to the bank counts
			count_shadow = count_shadow + 32'd1;
			if (addr[17:6] == 12'd0 && addr[5:2] == 4'd1) begin
				for (int b = 0; b < 4; b++) begin
					if (lanes[b]) begin
						scratch_shadow[8*b +: 8] = data[8*b +: 8];
					end
				end
			end
		end
	endfunction

	////////////////////////////////////////
	// Stimulus table

	task automatic push_entry(input string name, input vec_t v);
		table_q.push_back(v);
		name_q.push_back(name);
	endtask

	task automatic plain_write(input string name, input logic [18:0] addr,
		input logic [31:0] data, input logic [3:0] lanes);
		vec_t v;
		v       = '0;
		v.wr    = 1'b1;
		v.addr  = addr;
		v.data  = data;
		v.lanes = lanes;
		push_entry(name, v);
	endtask

	// All lanes, data from the seeded generator
	task automatic random_write(input string name, input logic [18:0] addr);
		plain_write(name, addr, $urandom(), 4'b1111);
	endtask

	task automatic fixed_read(input string name, input logic [18:0] addr,
		input logic [31:0] expv);
		vec_t v;
		v      = '0;
		v.addr = addr;
		v.expv = expv;
		push_entry(name, v);
	endtask

	// Expected value comes from the shadow when the entry runs
	task automatic shadow_read(input string name, input logic [18:0] addr);
		vec_t v;
		v          = '0;
		v.computed = 1'b1;
		v.addr     = addr;
		push_entry(name, v);
	endtask

	task automatic build_table();
		fixed_read("id_read", 19'h00000, id_word);
		shadow_read("count_reset", 19'h00008);
		// Scratch, full word then partial lanes
		plain_write("scratch_all", 19'h00004, 32'ha5a5_5a5a, 4'b1111);
		shadow_read("scratch_all_rd", 19'h00004);
		plain_write("scratch_b0", 19'h00004, 32'h1111_11c3, 4'b0001);
		shadow_read("scratch_b0_rd", 19'h00004);
		plain_write("scratch_b1_b3", 19'h00004, 32'hdead_beef, 4'b1010);
		shadow_read("scratch_b1_b3_rd", 19'h00004);
		plain_write("scratch_b2", 19'h00004, 32'h0077_0000, 4'b0100);
		shadow_read("scratch_b2_rd", 19'h00004);
		shadow_read("count_scratch", 19'h00008);
		// Counter counts a write to itself and drops the data
		plain_write("count_self", 19'h00008, 32'hffff_ffff, 4'b1111);
		shadow_read("count_self_rd", 19'h00008);
		// SRAM words, the last write aliases word 2
		random_write("sram_w0", 19'h40000);
		random_write("sram_w1", 19'h40004);
		random_write("sram_w2", 19'h40008);
		random_write("sram_w72", 19'h40120);
		random_write("sram_w255", 19'h403fc);
		random_write("sram_alias", 19'h40408);
		shadow_read("sram_w0_rd", 19'h40000);
		shadow_read("sram_w1_rd", 19'h40004);
		shadow_read("sram_w2_rd", 19'h40008);
		shadow_read("sram_w72_rd", 19'h40120);
		shadow_read("sram_w255_rd", 19'h403fc);
		shadow_read("sram_alias_rd", 19'h40408);
		shadow_read("count_sram", 19'h00008);
		// Read straight after a write to the same word
		random_write("b2b_w", 19'h40040);
		shadow_read("b2b_rd", 19'h40040);
		plain_write("b2b_part_w", 19'h40040, 32'h1234_5678, 4'b0110);
		shadow_read("b2b_part_rd", 19'h40040);
		// Holes in the register map
		random_write("sram_w3", 19'h4000c);
		random_write("sram_w65", 19'h40104);
		fixed_read("hole_c_rd", 19'h0000c, 32'h0);
		fixed_read("hole_3c_rd", 19'h0003c, 32'h0);
		fixed_read("hole_104_rd", 19'h00104, 32'h0);
		plain_write("hole_c_w", 19'h0000c, 32'hffff_ffff, 4'b1111);
		plain_write("hole_104_w", 19'h00104, 32'h5555_5555, 4'b1111);
		fixed_read("hole_c_after", 19'h0000c, 32'h0);
		shadow_read("scratch_holes", 19'h00004);
		shadow_read("sram_w3_holes", 19'h4000c);
		shadow_read("sram_w65_holes", 19'h40104);
		shadow_read("count_final", 19'h00008);
	endtask

	////////////////////////////////////////
	// Check loop

	task automatic apply_entry(input int idx);
		vec_t        v;
		logic [31:0] got;
		logic [31:0] want;
		v       = table_q[idx];
		cur_idx = idx;
		if (v.wr) begin
			write_word(v.addr, v.data, v.lanes);
			apply_write(v.addr, v.data, v.lanes);
		end else begin
			want = v.computed ? predict_read(v.addr) : v.expv;
			read_word(v.addr, got);
			// Halves checked apart
			checks = checks + 2;
			if (got[15:0] !== want[15:0]) begin
				errors = errors + 1;
				$display("error: %s low half expected %h actual %h",
					name_q[idx], want[15:0], got[15:0]);
			end
			if (got[31:16] !== want[31:16]) begin
				errors = errors + 1;
				$display("error: %s high half expected %h actual %h",
					name_q[idx], want[31:16], got[31:16]);
			end
		end
	endtask

	initial begin
		apb         = 1'b0;
		rst_n       = 1'b0;
		fmc_cs_n    = 1'b1;
		fmc_nl_nadv = 1'b1;
		fmc_nwe     = 1'b1;
		fmc_noe     = 1'b1;
		fmc_nbl     = 2'b11;
		fmc_a_hi    = 3'd0;
		ad_drive    = 1'b0;
		ad_val      = 16'h0000;
		scratch_shadow = '0;
		count_shadow   = '0;
		for (int i = 0; i < sram_words; i++) begin
			sram_shadow[i] = '0;
		end
		void'($urandom(32'h220e5289));
		build_table();

		// Five cycles in reset
		repeat (5) next_fall();
		rst_n = 1'b1;
		settle();
		checks = checks + 1;
		if (fmc_nwait !== 1'b1) begin
			errors = errors + 1;
			$display("fmc_nwait was not high after reset");
		end
		next_fall();

		for (int i = 0; i < table_q.size(); i++) begin
			apply_entry(i);
		end

		$display("summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

/* logic/fmc_apb_top.sv */
`timescale 1ns/10ps

module fmc_apb_top #(
	parameter bit          early_read = 1'b1,
	parameter int unsigned sram_words = 256
) (
	// FMC clock is also the APB clock
	input  logic        apb,
	input  logic        rst_n,

	input  logic        fmc_cs_n,
	input  logic        fmc_nl_nadv,
	input  logic        fmc_nwe,
	input  logic        fmc_noe,
	input  logic [1:0]  fmc_nbl,
	input  logic [2:0]  fmc_a_hi,
	inout  wire  [15:0] fmc_ad,
	output logic        fmc_nwait
);

	import fmc_apb_pkg::*;

	////////////////////////////////////////
	// APB root bus

	apb_req_t req;
	apb_rsp_t rsp;
	apb_rsp_t rsp_regs;
	apb_rsp_t rsp_sram;
	logic     psel_any;
	logic     sel_regs;
	logic     sel_sram;

	// Single requester
	fmc_apb_bridge #(
		.early_read (early_read)
	) fmc_apb_bridge_i (
		.apb         (apb),
		.rst_n       (rst_n),
		.fmc_cs_n    (fmc_cs_n),
		.fmc_nl_nadv (fmc_nl_nadv),
		.fmc_nwe     (fmc_nwe),
		.fmc_noe     (fmc_noe),
		.fmc_nbl     (fmc_nbl),
		.fmc_a_hi    (fmc_a_hi),
		.fmc_ad      (fmc_ad),
		.fmc_nwait   (fmc_nwait),
		.req         (req),
		.psel_any    (psel_any),
		.rsp         (rsp)
	);

	apb_decoder apb_decoder_i (
		.apb      (apb),
		.rst_n    (rst_n),
		.psel_any (psel_any),
		.req      (req),
		.sel_regs (sel_regs),
		.sel_sram (sel_sram),
		.rsp_regs (rsp_regs),
		.rsp_sram (rsp_sram),
		.rsp      (rsp)
	);

	// Register region, bit 18 low
	apb_reg_bank apb_reg_bank_i (
		.apb   (apb),
		.rst_n (rst_n),
		.sel   (sel_regs),
		.req   (req),
		.rsp   (rsp_regs)
	);

	// Memory region, bit 18 high
	apb_sram #(
		.sram_words (sram_words)
	) apb_sram_i (
		.apb   (apb),
		.rst_n (rst_n),
		.sel   (sel_sram),
		.req   (req),
		.rsp   (rsp_sram)
	);

endmodule

/* logic/apb_sram.sv */
`timescale 1ns/10ps

module apb_sram #(
	// Depth in 32-bit words, power of two
	parameter int unsigned sram_words = 256
) (
	input  logic                  apb,
	input  logic                  rst_n,

	// APB completer port
	input  logic                  sel,
	input  fmc_apb_pkg::apb_req_t req,
	output fmc_apb_pkg::apb_rsp_t rsp
);

	import fmc_apb_pkg::*;

	localparam int idx_width = $clog2(sram_words);

	apb_data_t              mem [sram_words];
	apb_data_t              rdata_q;
	// Word index, truncation wraps the address modulo the depth
	logic [idx_width-1:0]   idx;
	// High in the second access cycle
	logic                   wait_q;
	logic                   access;

	assign idx    = req.paddr[2 +: idx_width];
	assign access = sel & req.penable;

	////////////////////////////////////////
	// Wait state

	always_ff @(posedge apb) begin
		if (!rst_n) begin
			wait_q <= 1'b0;
		end else if (access) begin
			// Toggles back to zero at pready
			wait_q <= ~wait_q;
		end
	end

	////////////////////////////////////////
	// Array

	always_ff @(posedge apb) begin
		// Read data registered in the first access cycle
		if (access && !wait_q) begin
			rdata_q <= mem[idx];
		end
		// Writes commit at pready
		if (access && wait_q && req.pwrite) begin
			for (int i = 0; i < apb_strb_width; i++) begin
				if (req.pstrb[i]) begin
					mem[idx][8*i +: 8] <= req.pwdata[8*i +: 8];
				end
			end
		end
	end

	always_comb begin
		rsp.prdata  = rdata_q;
		rsp.pready  = access & wait_q;
		rsp.pslverr = 1'b0;
	end

endmodule

/* logic/apb_reg_bank.sv */
`timescale 1ns/10ps

module apb_reg_bank (
	input  logic                  apb,
	input  logic                  rst_n,

	// APB completer port
	input  logic                  sel,
	input  fmc_apb_pkg::apb_req_t req,
	output fmc_apb_pkg::apb_rsp_t rsp
);

	import fmc_apb_pkg::*;

	reg_offset_e offset;
	// Offset lies inside the 16-word register window
	logic        hit;
	logic        wr_en;
	apb_data_t   rd_data;

	apb_data_t   scratch;
	apb_data_t   wr_count;

	////////////////////////////////////////
	// Decode

	assign offset = reg_offset_e'(req.paddr[5:2]);
	// Bits above the window must be clear, bit 18 is the region
	assign hit    = (req.paddr[apb_addr_width-2:6] == '0);

	// Zero wait states, access completes in its first cycle
	assign wr_en  = sel & req.penable & req.pwrite;

	////////////////////////////////////////
	// Registers

	always_ff @(posedge apb) begin
		if (!rst_n) begin
			scratch  <= '0;
			wr_count <= '0;
		end else if (wr_en) begin
			// Every completed write counts, even one to the counter itself
			wr_count <= wr_count + 32'd1;
			if (hit && offset == reg_scratch) begin
				for (int i = 0; i < apb_strb_width; i++) begin
					if (req.pstrb[i]) begin
						scratch[8*i +: 8] <= req.pwdata[8*i +: 8];
					end
				end
			end
		end
	end

	////////////////////////////////////////
	// Read mux

	always_comb begin
		rd_data = '0;
		if (hit) begin
			case (offset)
				reg_id:       rd_data = reg_id_value;
				reg_scratch:  rd_data = scratch;
				reg_wr_count: rd_data = wr_count;
				// Holes read zero
				default:      rd_data = '0;
			endcase
		end
	end

	always_comb begin
		rsp.prdata  = rd_data;
		rsp.pready  = sel & req.penable;
		rsp.pslverr = 1'b0;
	end

endmodule

/* logic/apb_decoder.sv */
`timescale 1ns/10ps

module apb_decoder (
	input  logic                  apb,
	input  logic                  rst_n,

	// Single select from the requester
	input  logic                  psel_any,
	input  fmc_apb_pkg::apb_req_t req,

	// Completer selects
	output logic                  sel_regs,
	output logic                  sel_sram,

	// Completer responses and the merged one
	input  fmc_apb_pkg::apb_rsp_t rsp_regs,
	input  fmc_apb_pkg::apb_rsp_t rsp_sram,
	output fmc_apb_pkg::apb_rsp_t rsp
);

	import fmc_apb_pkg::*;

	// Top address bit picks the region
	localparam int region_bit = apb_addr_width - 1;

	// Region of the open access, taken at setup
	logic region_sram;

	////////////////////////////////////////
	// Select split

	// Low half of the map is the register bank
	assign sel_regs = psel_any & ~req.paddr[region_bit];
	assign sel_sram = psel_any &  req.paddr[region_bit];

	// Latch the region in the setup cycle
	always_ff @(posedge apb) begin
		if (!rst_n) begin
			region_sram <= 1'b0;
		end else if (psel_any && !req.penable) begin
			region_sram <= req.paddr[region_bit];
		end
	end

	////////////////////////////////////////
	// Response mux

	// Zero response outside an access phase
	always_comb begin
		rsp = '0;
		if (psel_any && req.penable) begin
			if (region_sram) begin
				rsp = rsp_sram;
			end else begin
				rsp = rsp_regs;
			end
		end
	end

endmodule

/* fmc_bridge/fmc_apb_bridge.sv */
`timescale 1ns/10ps

module fmc_apb_bridge #(
	// Drive the low read half straight from the completer in the pready cycle
	parameter bit early_read = 1'b1
) (
	input  logic                  apb,
	input  logic                  rst_n,

	// FMC pins from the host
	input  logic                  fmc_cs_n,
	input  logic                  fmc_nl_nadv,
	input  logic                  fmc_nwe,
	input  logic                  fmc_noe,
	input  logic [1:0]            fmc_nbl,
	input  logic [2:0]            fmc_a_hi,
	inout  wire  [15:0]           fmc_ad,
	output logic                  fmc_nwait,

	// APB requester side
	output fmc_apb_pkg::apb_req_t req,
	output logic                  psel_any,
	input  fmc_apb_pkg::apb_rsp_t rsp
);

	import fmc_apb_pkg::*;

	// Round trip from nwait rising to the host moving on
	localparam int wait_cycle_rtt = 2;

	bridge_state_e state;

	// Address latched in the address phase
	apb_addr_t     pending_addr;
	apb_addr_t     addr_in;
	// An APB access is open
	logic          busy;
	logic [1:0]    wait_count;

	// Low write half and its lanes, kept apart from req until launch
	logic [15:0]   wr_lo;
	logic [1:0]    wr_strb_lo;

	// Read data captured at pready
	apb_data_t     prdata_q;
	// Value driven onto the AD bus
	logic [15:0]   ad_out;

	logic          rd_go;
	apb_addr_t     rd_addr;

	////////////////////////////////////////
	// Pins

	// Bit 16 is on both a_hi[0] and ad[15], take it from a_hi
	// Bit 0 is always zero on a 16-bit bus
	assign addr_in = {fmc_a_hi, fmc_ad[14:0], 1'b0};

	// Drive AD only during a selected read
	assign fmc_ad = (!fmc_noe && !fmc_cs_n) ? ad_out : 16'hzzzz;

	// Host is held off exactly while an access is open
	assign fmc_nwait = fmc_cs_n | ~busy;

	// Read launch
	// Straight from the address phase, or later once the open access drains
	always_comb begin
		rd_go   = 1'b0;
		rd_addr = addr_in;
		if (!fmc_cs_n && !busy) begin
			if (state == st_addr && fmc_nwe) begin
				rd_go = 1'b1;
			end else if (state == st_wait) begin
				rd_go   = 1'b1;
				rd_addr = pending_addr;
			end
		end
	end

	////////////////////////////////////////
	// APB sequencing and FSM

	always_ff @(posedge apb) begin
		if (!rst_n) begin
			state      <= st_idle;
			busy       <= 1'b0;
			psel_any   <= 1'b0;
			req        <= '0;
			wait_count <= '0;
		end else begin
			// Setup cycle done, move to access
			if (psel_any && !req.penable) begin
				req.penable <= 1'b1;
			end

			// Access complete, drop select next cycle
			if (req.penable && rsp.pready) begin
				psel_any    <= 1'b0;
				req.penable <= 1'b0;
				busy        <= 1'b0;
				prdata_q    <= rsp.prdata;
			end

			// Read setup cycle
			if (rd_go) begin
				req.paddr   <= rd_addr;
				req.pwrite  <= 1'b0;
				req.pstrb   <= '0;
				req.penable <= 1'b0;
				psel_any    <= 1'b1;
				busy        <= 1'b1;
			end

			if (!fmc_cs_n) begin
				case (state)
					// Address phase opens with nadv low
					st_idle: begin
						if (!fmc_nl_nadv) begin
							state <= st_addr;
						end
					end

					// Address and nwe valid here
					st_addr: begin
						pending_addr <= addr_in;
						if (!fmc_nwe) begin
							state <= st_wdata_lo;
						end else if (rd_go) begin
							state <= st_rdata_lo;
						end else begin
							state <= st_wait;
						end
					end

					// Read blocked behind an open access
					st_wait: begin
						if (rd_go) begin
							state <= st_rdata_lo;
						end
					end

					////////////////////////////////////////
					// Writes

					// Host holds the low half while nwait is low
					st_wdata_lo: begin
						wr_lo      <= fmc_ad;
						wr_strb_lo <= ~fmc_nbl;
						if (!fmc_nwait) begin
							state      <= st_wdata_wait;
							wait_count <= '0;
						end else begin
							state <= st_wdata_hi;
						end
					end

					// Let the host see nwait before the high half
					st_wdata_wait: begin
						if (fmc_nwait) begin
							wait_count <= wait_count + 2'd1;
							if (wait_count >= 2'(wait_cycle_rtt)) begin
								state <= st_wdata_hi;
							end
						end
					end

					// High half completes the word, start the setup cycle
					st_wdata_hi: begin
						req.paddr   <= pending_addr;
						req.pwrite  <= 1'b1;
						req.pwdata  <= {fmc_ad, wr_lo};
						req.pstrb   <= {~fmc_nbl, wr_strb_lo};
						req.penable <= 1'b0;
						psel_any    <= 1'b1;
						busy        <= 1'b1;
						state       <= st_active;
					end

					////////////////////////////////////////
					// Reads

					st_rdata_lo: begin
						// Early copy one cycle ahead of the host sample
						if (early_read && busy && req.penable && rsp.pready) begin
							ad_out <= rsp.prdata[15:0];
						end
						// Host sees nwait high now, low half at next edge
						if (!busy) begin
							if (!early_read) begin
								ad_out <= prdata_q[15:0];
							end
							state <= st_rdata_hi;
						end
					end

					st_rdata_hi: begin
						ad_out <= prdata_q[31:16];
						state  <= st_rd_end;
					end

					// Hold the high half until deselect
					st_rd_end: begin
						state <= st_rd_end;
					end

					default: begin
						state <= state;
					end
				endcase
			end else begin
				// Deselect ends the FMC transaction, APB may still run
				state <= st_idle;
			end
		end
	end

endmodule

/* common/fmc_apb_pkg.sv */
package fmc_apb_pkg;

	////////////////////////////////////////
	// Bus widths

	// Byte address seen by the APB root bus
	localparam int apb_addr_width = 19;
	localparam int apb_data_width = 32;
	// One strobe per byte lane
	localparam int apb_strb_width = apb_data_width / 8;

	typedef logic [apb_addr_width-1:0] apb_addr_t;
	typedef logic [apb_data_width-1:0] apb_data_t;

	////////////////////////////////////////
	// APB request and response

	// Requester to completers, psel travels separately
	typedef struct packed {
		apb_addr_t                 paddr;
		logic                      pwrite;
		apb_data_t                 pwdata;
		logic [apb_strb_width-1:0] pstrb;
		logic                      penable;
	} apb_req_t;

	// Completer to requester
	typedef struct packed {
		apb_data_t prdata;
		logic      pready;
		// Tied low by every completer here
		logic      pslverr;
	} apb_rsp_t;

	////////////////////////////////////////
	// Bridge FSM states

	typedef enum logic [3:0] {
		// Common path
		st_idle,
		st_addr,
		st_wait,
		// Write data halves
		st_wdata_lo,
		st_wdata_wait,
		st_wdata_hi,
		// Read data halves
		st_rdata_lo,
		st_rdata_hi,
		st_rd_end,
		// Write in flight, wait for deselect
		st_active
	} bridge_state_e;

	////////////////////////////////////////
	// Register bank map

	// Word offsets inside the register region
	typedef enum logic [3:0] {
		reg_id       = 4'd0,
		reg_scratch  = 4'd1,
		reg_wr_count = 4'd2
	} reg_offset_e;

	// ASCII "FMCA"
	localparam apb_data_t reg_id_value = 32'h464d_4341;

endpackage
